/* source/rs2d_consts.svh */
`ifndef RS2D_CONSTS_SVH
`define RS2D_CONSTS_SVH

// Symbols per row or column, data plus checks
`define RS2D_N 6

// Data symbols per row or column
`define RS2D_K 4

// GF(16) symbol width in bits
`define RS2D_SYM_W 4

// Multiplicative order of the field, alpha^15 = 1
`define RS2D_GF_ORDER 15

// Width of the iteration limit input
`define RS2D_ITER_W 4

`endif

/* source/gf_pkg.sv */
`include "rs2d_consts.svh"

package gf_pkg;

    typedef logic [`RS2D_SYM_W-1:0] symbol_t;

    // Exponent sum before reduction mod 15
    typedef logic [`RS2D_SYM_W:0] exp_sum_t;

    // Powers of alpha for x^4 + x + 1
    function automatic symbol_t gf_alog(input symbol_t e);
        symbol_t r;
        case (e)
            4'd0:    r = 4'h1;
            4'd1:    r = 4'h2;
            4'd2:    r = 4'h4;
            4'd3:    r = 4'h8;
            4'd4:    r = 4'h3;
            4'd5:    r = 4'h6;
            4'd6:    r = 4'hc;
            4'd7:    r = 4'hb;
            4'd8:    r = 4'h5;
            4'd9:    r = 4'ha;
            4'd10:   r = 4'h7;
            4'd11:   r = 4'he;
            4'd12:   r = 4'hf;
            4'd13:   r = 4'hd;
            4'd14:   r = 4'h9;
            default: r = 4'h1;
        endcase
        return r;
    endfunction

    // Discrete log, zero has none and maps to 0
    function automatic symbol_t gf_log(input symbol_t x);
        symbol_t r;
        case (x)
            4'h1:    r = 4'd0;
            4'h2:    r = 4'd1;
            4'h3:    r = 4'd4;
            4'h4:    r = 4'd2;
            4'h5:    r = 4'd8;
            4'h6:    r = 4'd5;
            4'h7:    r = 4'd10;
            4'h8:    r = 4'd3;
            4'h9:    r = 4'd14;
            4'ha:    r = 4'd9;
            4'hb:    r = 4'd7;
            4'hc:    r = 4'd6;
            4'hd:    r = 4'd13;
            4'he:    r = 4'd11;
            4'hf:    r = 4'd12;
            default: r = 4'd0;
        endcase
        return r;
    endfunction

    function automatic symbol_t gf_mul(input symbol_t a, input symbol_t b);
        exp_sum_t e;
        if (a == '0 || b == '0) begin
            return '0;
        end
        e = {1'b0, gf_log(a)} + {1'b0, gf_log(b)};
        if (e >= exp_sum_t'(`RS2D_GF_ORDER)) begin
            e = e - exp_sum_t'(`RS2D_GF_ORDER);
        end
        return gf_alog(e[`RS2D_SYM_W-1:0]);
    endfunction

endpackage

/* source/rs2d_pkg.sv */
`include "rs2d_consts.svh"

package rs2d_pkg;

    // Row or column number
    typedef logic [$clog2(`RS2D_N)-1:0] index_t;

    // One row or column, element j is the symbol at position j
    typedef gf_pkg::symbol_t [`RS2D_N-1:0] line_t;

    // Output stream beat
    typedef struct packed {
        logic            last;
        gf_pkg::symbol_t sym;
    } out_beat_t;

    // Decoder phases, ROWS COLS CHECK repeat per iteration
    typedef enum logic [2:0] {
        LOAD,
        ROWS,
        COLS,
        CHECK,
        UNLOAD
    } phase_t;

endpackage

/* source/stream_skid.sv */
module stream_skid #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rstn,
    input  logic     s_valid,
    output logic     s_ready,
    input  payload_t s_data,
    output logic     m_valid,
    input  logic     m_ready,
    output payload_t m_data
);
    logic     skid_valid;
    payload_t skid_data;
    logic     s_fire;
    logic     m_open;

    assign s_fire  = s_valid && s_ready;
    // Output register is free or being emptied this cycle
    assign m_open  = m_ready || !m_valid;
    // Ready comes straight from a flop
    assign s_ready = !skid_valid;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            m_valid    <= 1'b0;
            skid_valid <= 1'b0;
        end else if (m_open) begin
            m_valid    <= skid_valid || s_fire;
            skid_valid <= 1'b0;
        end else if (s_fire) begin
            // Output stalled, park the beat
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (m_open) begin
            if (skid_valid) begin
                m_data <= skid_data;
            end else if (s_fire) begin
                m_data <= s_data;
            end
        end else if (s_fire) begin
            skid_data <= s_data;
        end
    end

    a_hold_stalled_beat: assert property (@(posedge clk) disable iff (!rstn)
        (m_valid && !m_ready) |=> (m_valid && $stable(m_data)));

endmodule

/* source/product_array.sv */
`include "rs2d_consts.svh"

module product_array (
    input  logic             clk,
    input  logic             rstn,
    input  logic             load_en,
    input  gf_pkg::symbol_t  load_sym,
    input  logic             rd_dir,
    input  rs2d_pkg::index_t rd_idx,
    output rs2d_pkg::line_t  rd_line,
    input  logic             wb_en,
    input  logic             wb_dir,
    input  rs2d_pkg::index_t wb_idx,
    input  rs2d_pkg::line_t  wb_line,
    input  rs2d_pkg::index_t unload_row,
    input  rs2d_pkg::index_t unload_col,
    output gf_pkg::symbol_t  unload_sym
);
    localparam rs2d_pkg::index_t LAST_IDX = rs2d_pkg::index_t'(`RS2D_N - 1);

    gf_pkg::symbol_t  mem [`RS2D_N][`RS2D_N];
    rs2d_pkg::index_t load_row;
    rs2d_pkg::index_t load_col;

    // Raster position of the next incoming symbol, wraps after a full block
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            load_row <= '0;
            load_col <= '0;
        end else if (load_en) begin
            if (load_col == LAST_IDX) begin
                load_col <= '0;
                load_row <= (load_row == LAST_IDX) ? '0 : load_row + 1'b1;
            end else begin
                load_col <= load_col + 1'b1;
            end
        end
    end

    // Direction 0 is a row, 1 is a column
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_row][load_col] <= load_sym;
        end
        if (wb_en) begin
            for (int j = 0; j < `RS2D_N; j++) begin
                if (wb_dir) begin
                    mem[j][wb_idx] <= wb_line[j];
                end else begin
                    mem[wb_idx][j] <= wb_line[j];
                end
            end
        end
    end

    always_comb begin
        for (int j = 0; j < `RS2D_N; j++) begin
            rd_line[j] = rd_dir ? mem[j][rd_idx] : mem[rd_idx][j];
        end
    end

    assign unload_sym = mem[unload_row][unload_col];

    // Loading and line decoding never share a cycle
    a_no_load_during_wb: assert property (@(posedge clk) disable iff (!rstn)
        !(load_en && wb_en));

endmodule

/* source/rs_line_decoder.sv */
`include "rs2d_consts.svh"

module rs_line_decoder (
    input  logic             clk,
    input  logic             rstn,
    input  logic             issue_valid,
    input  logic             issue_dir,
    input  rs2d_pkg::index_t issue_idx,
    input  rs2d_pkg::line_t  issue_line,
    output logic             wb_valid,
    output logic             wb_dir,
    output rs2d_pkg::index_t wb_idx,
    output rs2d_pkg::line_t  wb_line,
    output logic             changed
);
    gf_pkg::symbol_t   s0_c;
    gf_pkg::symbol_t   s1_c;
    logic              st1_valid;
    logic              st1_dir;
    rs2d_pkg::index_t  st1_idx;
    rs2d_pkg::line_t   st1_line;
    gf_pkg::symbol_t   st1_s0;
    gf_pkg::symbol_t   st1_s1;
    gf_pkg::exp_sum_t  pos;
    logic              fixable;
    rs2d_pkg::line_t   fixed_line;

    // S0 = sum s_j, S1 = sum s_j * alpha^j
    always_comb begin
        s0_c = '0;
        s1_c = '0;
        for (int j = 0; j < `RS2D_N; j++) begin
            s0_c = s0_c ^ issue_line[j];
            s1_c = s1_c ^ gf_pkg::gf_mul(issue_line[j], gf_pkg::gf_alog(gf_pkg::symbol_t'(j)));
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            st1_valid <= 1'b0;
        end else begin
            st1_valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        st1_dir  <= issue_dir;
        st1_idx  <= issue_idx;
        st1_line <= issue_line;
        st1_s0   <= s0_c;
        st1_s1   <= s1_c;
    end

    // Single error at j gives S1/S0 = alpha^j
    always_comb begin
        pos = {1'b0, gf_pkg::gf_log(st1_s1)} + gf_pkg::exp_sum_t'(`RS2D_GF_ORDER)
            - {1'b0, gf_pkg::gf_log(st1_s0)};
        if (pos >= gf_pkg::exp_sum_t'(`RS2D_GF_ORDER)) begin
            pos = pos - gf_pkg::exp_sum_t'(`RS2D_GF_ORDER);
        end
        // Positions past the shortened length mean more than one error
        fixable = (st1_s0 != '0) && (st1_s1 != '0)
            && (pos < gf_pkg::exp_sum_t'(`RS2D_N));
        fixed_line = st1_line;
        for (int j = 0; j < `RS2D_N; j++) begin
            if (fixable && pos == gf_pkg::exp_sum_t'(j)) begin
                fixed_line[j] = st1_line[j] ^ st1_s0;
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wb_valid <= 1'b0;
            changed  <= 1'b0;
        end else begin
            wb_valid <= st1_valid;
            changed  <= st1_valid && fixable;
        end
    end

    always_ff @(posedge clk) begin
        wb_dir  <= st1_dir;
        wb_idx  <= st1_idx;
        wb_line <= fixed_line;
    end

    a_two_cycle_latency: assert property (@(posedge clk) disable iff (!rstn)
        wb_valid == $past(issue_valid, 2));

endmodule

/* source/iter_ctrl.sv */
`include "rs2d_consts.svh"

module iter_ctrl (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic [`RS2D_ITER_W-1:0] max_iterations,
    input  logic                    in_valid,
    input  logic                    in_ready_skid,
    output logic                    load_en,
    output logic                    rd_dir,
    output rs2d_pkg::index_t        rd_idx,
    output logic                    issue_valid,
    input  logic                    wb_valid,
    input  logic                    changed,
    output rs2d_pkg::index_t        unload_row,
    output rs2d_pkg::index_t        unload_col,
    output logic                    out_valid,
    output logic                    out_last,
    input  logic                    out_ready_skid
);
    localparam int LOAD_W = $clog2(`RS2D_N * `RS2D_N);
    localparam int STEP_W = $clog2(`RS2D_N + 2);
    localparam int CHG_W  = $clog2(2 * `RS2D_N + 1);
    localparam logic [LOAD_W-1:0] LOAD_LAST = LOAD_W'(`RS2D_N * `RS2D_N - 1);
    // N issue steps then two drain steps per direction
    localparam logic [STEP_W-1:0] STEP_LAST   = STEP_W'(`RS2D_N + 1);
    localparam logic [STEP_W-1:0] ISSUE_STEPS = STEP_W'(`RS2D_N);
    localparam rs2d_pkg::index_t DATA_LAST = rs2d_pkg::index_t'(`RS2D_K - 1);
    localparam logic [`RS2D_ITER_W-1:0] ITER_ONE = 1;

    rs2d_pkg::phase_t        phase;
    logic [LOAD_W-1:0]       load_cnt;
    logic [STEP_W-1:0]       step;
    logic [CHG_W-1:0]        change_cnt;
    logic [`RS2D_ITER_W-1:0] iter_cnt;
    logic [`RS2D_ITER_W-1:0] iter_limit;
    logic                    line_phase;
    logic                    stop;
    logic                    out_fire;

    assign line_phase  = (phase == rs2d_pkg::ROWS) || (phase == rs2d_pkg::COLS);
    assign load_en     = in_valid && (phase == rs2d_pkg::LOAD);
    assign rd_dir      = (phase == rs2d_pkg::COLS);
    assign rd_idx      = rs2d_pkg::index_t'(step);
    assign issue_valid = line_phase && (step < ISSUE_STEPS);
    assign out_valid   = (phase == rs2d_pkg::UNLOAD);
    assign out_last    = (unload_row == DATA_LAST) && (unload_col == DATA_LAST);
    assign out_fire    = out_valid && out_ready_skid;
    // Zero limit still runs one iteration
    assign iter_limit  = (max_iterations == '0) ? ITER_ONE : max_iterations;
    assign stop        = (change_cnt == '0)
        || (({1'b0, iter_cnt} + 1'b1) >= {1'b0, iter_limit});

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            phase      <= rs2d_pkg::LOAD;
            load_cnt   <= '0;
            step       <= '0;
            change_cnt <= '0;
            iter_cnt   <= '0;
            unload_row <= '0;
            unload_col <= '0;
        end else begin
            if (wb_valid && changed) begin
                change_cnt <= change_cnt + 1'b1;
            end
            case (phase)
                rs2d_pkg::LOAD: begin
                    if (load_en) begin
                        load_cnt <= (load_cnt == LOAD_LAST) ? '0 : load_cnt + 1'b1;
                        if (load_cnt == LOAD_LAST) begin
                            phase      <= rs2d_pkg::ROWS;
                            step       <= '0;
                            iter_cnt   <= '0;
                            change_cnt <= '0;
                        end
                    end
                end
                rs2d_pkg::ROWS, rs2d_pkg::COLS: begin
                    if (step == STEP_LAST) begin
                        step  <= '0;
                        phase <= (phase == rs2d_pkg::ROWS) ? rs2d_pkg::COLS : rs2d_pkg::CHECK;
                    end else begin
                        step <= step + 1'b1;
                    end
                end
                rs2d_pkg::CHECK: begin
                    iter_cnt   <= iter_cnt + 1'b1;
                    change_cnt <= '0;
                    unload_row <= '0;
                    unload_col <= '0;
                    phase      <= stop ? rs2d_pkg::UNLOAD : rs2d_pkg::ROWS;
                end
                rs2d_pkg::UNLOAD: begin
                    if (out_fire) begin
                        if (out_last) begin
                            phase <= rs2d_pkg::LOAD;
                        end else if (unload_col == DATA_LAST) begin
                            unload_col <= '0;
                            unload_row <= unload_row + 1'b1;
                        end else begin
                            unload_col <= unload_col + 1'b1;
                        end
                    end
                end
                default: phase <= rs2d_pkg::LOAD;
            endcase
        end
    end

    // Each issued line is written back before the phase moves on
    a_issue_in_line_phase: assert property (@(posedge clk) disable iff (!rstn)
        issue_valid |-> line_phase ##2 (wb_valid && phase == $past(phase, 2)));

    // A full input skid empties within one cycle of loading
    a_load_skid_drains: assert property (@(posedge clk) disable iff (!rstn)
        (phase == rs2d_pkg::LOAD && !in_ready_skid) |=> in_ready_skid);

endmodule

/* source/rs2d_decoder.sv */
`include "rs2d_consts.svh"

module rs2d_decoder (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic [`RS2D_ITER_W-1:0] max_iterations,
    input  logic                    in_valid,
    output logic                    in_ready,
    input  gf_pkg::symbol_t         in_sym,
    output logic                    out_valid,
    input  logic                    out_ready,
    output gf_pkg::symbol_t         out_sym,
    output logic                    out_last
);
    logic                load_valid;
    logic                load_en;
    gf_pkg::symbol_t     load_sym;
    logic                rd_dir;
    rs2d_pkg::index_t    rd_idx;
    rs2d_pkg::line_t     rd_line;
    logic                issue_valid;
    logic                wb_valid;
    logic                wb_dir;
    rs2d_pkg::index_t    wb_idx;
    rs2d_pkg::line_t     wb_line;
    logic                changed;
    rs2d_pkg::index_t    unload_row;
    rs2d_pkg::index_t    unload_col;
    gf_pkg::symbol_t     unload_sym;
    logic                beat_valid;
    logic                beat_last;
    logic                beat_ready;
    rs2d_pkg::out_beat_t out_beat;

    stream_skid #(.payload_t(gf_pkg::symbol_t)) in_skid (
        .clk     (clk),
        .rstn    (rstn),
        .s_valid (in_valid),
        .s_ready (in_ready),
        .s_data  (in_sym),
        .m_valid (load_valid),
        .m_ready (load_en),
        .m_data  (load_sym)
    );

    product_array u_array (
        .clk        (clk),
        .rstn       (rstn),
        .load_en    (load_en),
        .load_sym   (load_sym),
        .rd_dir     (rd_dir),
        .rd_idx     (rd_idx),
        .rd_line    (rd_line),
        .wb_en      (wb_valid),
        .wb_dir     (wb_dir),
        .wb_idx     (wb_idx),
        .wb_line    (wb_line),
        .unload_row (unload_row),
        .unload_col (unload_col),
        .unload_sym (unload_sym)
    );

    rs_line_decoder u_line_dec (
        .clk         (clk),
        .rstn        (rstn),
        .issue_valid (issue_valid),
        .issue_dir   (rd_dir),
        .issue_idx   (rd_idx),
        .issue_line  (rd_line),
        .wb_valid    (wb_valid),
        .wb_dir      (wb_dir),
        .wb_idx      (wb_idx),
        .wb_line     (wb_line),
        .changed     (changed)
    );

    iter_ctrl u_ctrl (
        .clk            (clk),
        .rstn           (rstn),
        .max_iterations (max_iterations),
        .in_valid       (load_valid),
        .in_ready_skid  (in_ready),
        .load_en        (load_en),
        .rd_dir         (rd_dir),
        .rd_idx         (rd_idx),
        .issue_valid    (issue_valid),
        .wb_valid       (wb_valid),
        .changed        (changed),
        .unload_row     (unload_row),
        .unload_col     (unload_col),
        .out_valid      (beat_valid),
        .out_last       (beat_last),
        .out_ready_skid (beat_ready)
    );

    stream_skid #(.payload_t(rs2d_pkg::out_beat_t)) out_skid (
        .clk     (clk),
        .rstn    (rstn),
        .s_valid (beat_valid),
        .s_ready (beat_ready),
        .s_data  ({beat_last, unload_sym}),
        .m_valid (out_valid),
        .m_ready (out_ready),
        .m_data  (out_beat)
    );

    assign out_sym  = out_beat.sym;
    assign out_last = out_beat.last;

endmodule

/* dv/rs2d_tb_model.svh */
`ifndef RS2D_TB_MODEL_SVH
`define RS2D_TB_MODEL_SVH

function automatic gf_pkg::symbol_t rand_symbol();
    return gf_pkg::symbol_t'($urandom_range(0, 15));
endfunction

function automatic gf_pkg::symbol_t rand_nonzero();
    return gf_pkg::symbol_t'($urandom_range(1, 15));
endfunction

function automatic gf_pkg::symbol_t gf_inverse(input gf_pkg::symbol_t x);
    int e;
    e = (`RS2D_GF_ORDER - int'(gf_pkg::gf_log(x))) % `RS2D_GF_ORDER;
    return gf_pkg::gf_alog(gf_pkg::symbol_t'(e));
endfunction

// Fills positions K and K+1 so that S0 and S1 vanish
function automatic rs2d_pkg::line_t add_checks(input rs2d_pkg::line_t ln);
    gf_pkg::symbol_t a;
    gf_pkg::symbol_t b;
    gf_pkg::symbol_t p;
    gf_pkg::symbol_t den;
    a = '0;
    b = '0;
    for (int j = 0; j < K; j++) begin
        a = a ^ ln[j];
        b = b ^ gf_pkg::gf_mul(ln[j], gf_pkg::gf_alog(gf_pkg::symbol_t'(j)));
    end
    // p_K (alpha^K + alpha^(K+1)) = b + a alpha^(K+1)
    den = gf_pkg::gf_alog(gf_pkg::symbol_t'(K)) ^ gf_pkg::gf_alog(gf_pkg::symbol_t'(K + 1));
    p = gf_pkg::gf_mul(b ^ gf_pkg::gf_mul(a, gf_pkg::gf_alog(gf_pkg::symbol_t'(K + 1))),
        gf_inverse(den));
    ln[K] = p;
    ln[K + 1] = a ^ p;
    return ln;
endfunction

// Single-error rule for one row or column
function automatic rs2d_pkg::line_t correct_line(input rs2d_pkg::line_t ln, output bit hit);
    gf_pkg::symbol_t s0;
    gf_pkg::symbol_t s1;
    int pos;
    rs2d_pkg::line_t res;
    s0 = '0;
    s1 = '0;
    for (int j = 0; j < N; j++) begin
        s0 = s0 ^ ln[j];
        s1 = s1 ^ gf_pkg::gf_mul(ln[j], gf_pkg::gf_alog(gf_pkg::symbol_t'(j)));
    end
    res = ln;
    hit = 1'b0;
    if (s0 != '0 && s1 != '0) begin
        pos = (int'(gf_pkg::gf_log(s1)) - int'(gf_pkg::gf_log(s0)) + `RS2D_GF_ORDER)
            % `RS2D_GF_ORDER;
        if (pos < N) begin
            res[pos] = res[pos] ^ s0;
            hit = 1'b1;
        end
    end
    return res;
endfunction

task automatic make_block();
    rs2d_pkg::line_t ln;
    for (int r = 0; r < K; r++) begin
        ln = '0;
        for (int c = 0; c < K; c++) begin
            ln[c] = rand_symbol();
        end
        ln = add_checks(ln);
        for (int c = 0; c < N; c++) begin
            clean[r][c] = ln[c];
        end
    end
    // Column checks also cover the row check columns
    for (int c = 0; c < N; c++) begin
        ln = '0;
        for (int r = 0; r < K; r++) begin
            ln[r] = clean[r][c];
        end
        ln = add_checks(ln);
        clean[K][c] = ln[K];
        clean[K + 1][c] = ln[K + 1];
    end
    blk = clean;
endtask

task automatic inject_error(input int r, input int c);
    blk[r][c] = blk[r][c] ^ rand_nonzero();
endtask

task automatic inject_square();
    int r;
    int c;
    r = $urandom_range(0, N - 2);
    c = $urandom_range(0, N - 2);
    inject_error(r, c);
    inject_error(r, c + 1);
    inject_error(r + 1, c);
    inject_error(r + 1, c + 1);
endtask

// Row pass then column pass, same stopping rule as the decoder
task automatic run_model(input int iters);
    rs2d_pkg::line_t ln;
    bit hit;
    int changes;
    int limit;
    mdl = blk;
    limit = (iters == 0) ? 1 : iters;
    for (int it = 0; it < limit; it++) begin
        changes = 0;
        for (int r = 0; r < N; r++) begin
            for (int j = 0; j < N; j++) begin
                ln[j] = mdl[r][j];
            end
            ln = correct_line(ln, hit);
            changes += int'(hit);
            for (int j = 0; j < N; j++) begin
                mdl[r][j] = ln[j];
            end
        end
        for (int c = 0; c < N; c++) begin
            for (int j = 0; j < N; j++) begin
                ln[j] = mdl[j][c];
            end
            ln = correct_line(ln, hit);
            changes += int'(hit);
            for (int j = 0; j < N; j++) begin
                mdl[j][c] = ln[j];
            end
        end
        if (changes == 0) begin
            break;
        end
    end
endtask

// Input symbols in raster order, expected data rows 0..K-1
task automatic queue_block(input bit predict, input int iters);
    if (predict) begin
        run_model(iters);
    end
    for (int r = 0; r < N; r++) begin
        for (int c = 0; c < N; c++) begin
            in_q.push_back(blk[r][c]);
        end
    end
    for (int r = 0; r < K; r++) begin
        for (int c = 0; c < K; c++) begin
            exp_q.push_back(predict ? mdl[r][c] : clean[r][c]);
        end
    end
endtask

`endif

/* dv/rs2d_tb.sv */
`include "rs2d_consts.svh"

module rs2d_tb;
    localparam int N = `RS2D_N;
    localparam int K = `RS2D_K;
    localparam int ITER_W = `RS2D_ITER_W;
    localparam int NUM_BLOCKS = 10;
    // Worst case per block with up to four iterations and slow output
    localparam int BLOCK_CYCLES = N * N + 17 * 4 + K * K * 4;
    localparam int TIMEOUT_CYCLES = NUM_BLOCKS * BLOCK_CYCLES + 200;

    typedef logic [ITER_W-1:0] iter_t;

    logic            clk = 1'b0;
    logic            rstn;
    iter_t           max_iterations;
    logic            in_valid;
    logic            in_ready;
    gf_pkg::symbol_t in_sym;
    logic            out_valid;
    logic            out_ready;
    gf_pkg::symbol_t out_sym;
    logic            out_last;

    gf_pkg::symbol_t blk [N][N];
    gf_pkg::symbol_t clean [N][N];
    gf_pkg::symbol_t mdl [N][N];
    gf_pkg::symbol_t in_q [$];
    gf_pkg::symbol_t exp_q [$];
    gf_pkg::symbol_t exp_sym;

    bit bp_en = 1'b0;
    bit input_overrun = 1'b0;
    int beat_cnt = 0;
    int blocks_started = 0;
    int total_in = 0;
    int cycles = 0;
    int errors = 0;
    int test_start_errors = 0;
    int tests_run = 0;
    int tests_failed = 0;

    `include "rs2d_tb_model.svh"

    rs2d_decoder dut0 (
        .clk            (clk),
        .rstn           (rstn),
        .max_iterations (max_iterations),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .in_sym         (in_sym),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .out_sym        (out_sym),
        .out_last       (out_last)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        out_ready <= bp_en ? ($urandom_range(0, 99) >= 30) : 1'b1;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // Output beats against the expected queue, input hold-off while busy
    always @(posedge clk) begin
        if (rstn) begin
            if (in_valid && in_ready) begin
                total_in++;
            end
            if (out_valid && out_ready) begin
                assert (exp_q.size() != 0) else begin
                    $display("Output beat arrived with no block pending");
                    errors++;
                end
                if (exp_q.size() != 0) begin
                    exp_sym = exp_q.pop_front();
                    assert (out_sym == exp_sym) else begin
                        $display("Fail out_sym: got 0x%h, expected 0x%h", out_sym, exp_sym);
                        errors++;
                    end
                    assert (out_last == (beat_cnt == K * K - 1)) else begin
                        $display("Fail out_last: got 0x%h, expected 0x%h",
                            out_last, (beat_cnt == K * K - 1));
                        errors++;
                    end
                    if (beat_cnt == 0) begin
                        blocks_started++;
                    end
                    beat_cnt = (beat_cnt == K * K - 1) ? 0 : beat_cnt + 1;
                end
            end
            // Only the input skid may take symbols of the next block
            if (!input_overrun) begin
                assert (total_in <= N * N * (blocks_started + 1) + 2) else begin
                    $display("Input accepted while the decoder was busy with a block");
                    errors++;
                    input_overrun = 1'b1;
                end
            end
        end
    end

    task automatic send_stream();
        while (in_q.size() != 0) begin
            in_valid <= 1'b1;
            in_sym   <= in_q.pop_front();
            @(posedge clk);
            while (!in_ready) begin
                @(posedge clk);
            end
        end
        in_valid <= 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
    endtask

    // Called at a falling edge right after the blocks are queued
    task automatic launch(input int limit, input bit bp);
        bp_en = bp;
        @(posedge clk);
        max_iterations <= iter_t'(limit);
        send_stream();
        wait_drain();
    endtask

    task automatic finish_test(input string name);
        int errs;
        errs = errors - test_start_errors;
        tests_run++;
        if (errs == 0) begin
            $display("Test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: %0d check(s) failed", tests_run, name, errs);
        end
        test_start_errors = errors;
    endtask

    initial begin
        int row;
        int col;
        void'($urandom(74984));
        rstn           = 1'b0;
        max_iterations = '0;
        in_valid       = 1'b0;
        in_sym         = '0;
        out_ready      = 1'b0;
        repeat (3) @(posedge clk);
        rstn <= 1'b1;

        @(negedge clk);
        make_block();
        queue_block(1'b0, 0);
        launch(3, 1'b0);
        finish_test("clean block");

        @(negedge clk);
        make_block();
        for (int r = 0; r < N; r++) begin
            inject_error(r, $urandom_range(0, N - 1));
        end
        queue_block(1'b0, 0);
        launch(3, 1'b0);
        finish_test("one error per row");

        // Two errors in a row leave one per column
        @(negedge clk);
        make_block();
        row = $urandom_range(0, N - 1);
        col = $urandom_range(0, N - 2);
        inject_error(row, col);
        inject_error(row, col + 1 + $urandom_range(0, N - 2 - col));
        queue_block(1'b0, 0);
        launch(2, 1'b0);
        finish_test("two errors in one row");

        @(negedge clk);
        make_block();
        inject_square();
        queue_block(1'b1, 1);
        launch(1, 1'b0);
        finish_test("error square, one iteration");

        // Same corrupted block, run to convergence
        @(negedge clk);
        queue_block(1'b1, 4);
        launch(4, 1'b0);
        finish_test("error square, four iterations");

        @(negedge clk);
        for (int b = 0; b < 2; b++) begin
            make_block();
            for (int r = 0; r < N; r++) begin
                if ($urandom_range(0, 1) == 1) begin
                    inject_error(r, $urandom_range(0, N - 1));
                end
            end
            queue_block(1'b0, 0);
        end
        launch(3, 1'b1);
        finish_test("output back-pressure, back-to-back blocks");

        @(negedge clk);
        for (int b = 0; b < 3; b++) begin
            make_block();
            inject_square();
            queue_block(1'b1, 1);
        end
        launch(0, 1'b1);
        finish_test("zero iteration limit, back-to-back blocks");

        $display("Summary: %0d tests, %0d failed, %0d failed checks",
            tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* rs2d.f */
+incdir+source
+incdir+dv
source/gf_pkg.sv
source/rs2d_pkg.sv
source/stream_skid.sv
source/product_array.sv
source/rs_line_decoder.sv
source/iter_ctrl.sv
source/rs2d_decoder.sv
dv/rs2d_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the rs2d testbench with Verilator

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG=sim.log
FAIL_MSG='\*\*\* FAILED \*\*\*'
PASS_MSG='\*\*\* PASSED \*\*\*'

verilator --binary --timing --assert -f rs2d.f --top-module rs2d_tb \
    -Mdir "$OBJ_DIR" -o rs2d_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ_DIR/rs2d_sim" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "$FAIL_MSG" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "Simulator exited with status $sim_status"
    exit 1
fi
if ! grep -q "$PASS_MSG" "$LOG"; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation passed"
exit 0
